/* logic/pdec_pkg.sv */
`default_nettype none

package pdec_pkg;

  // ==================================================
  // instruction field types
  // ==================================================

  // raw fetch word, an rvc instruction sits in [15:0]
  typedef logic [31:0] inst_t;

  typedef logic [4:0] reg_idx_t;  // rd / rs1 index
  typedef logic [6:0] opcode_t;   // major opcode, bits 6:0

  // ==================================================
  // major opcodes (32-bit forms)
  // ==================================================
  localparam opcode_t OPC_JAL    = 7'b1101111;  // jal
  localparam opcode_t OPC_JALR   = 7'b1100111;  // jalr, funct3 checked by user
  localparam opcode_t OPC_BRANCH = 7'b1100011;  // beq/bne/blt/bge/bltu/bgeu
  localparam opcode_t OPC_AUIPC  = 7'b0010111;  // auipc

  // ==================================================
  // register numbers for the return stack
  // ==================================================

  // x1 and x5 are both treated as link registers
  localparam reg_idx_t REG_ZERO = 5'd0;
  localparam reg_idx_t REG_RA   = 5'd1;  // ra
  localparam reg_idx_t REG_T0   = 5'd5;  // t0, alternate link

endpackage

`default_nettype wire

/* logic/pdec_in_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pdec_in_stage import pdec_pkg::*; (
  input  wire        forever_cpuclk,
  input  wire        rst,
  // fetch side
  input  wire        in_valid,
  output logic       in_ready,
  input  wire inst_t inst,
  input  wire        br,        // external branch hint
  // decode side
  output logic       dec_valid,
  input  wire        dec_ready,
  output inst_t      dec_inst,
  output logic       dec_br
);

  // ==================================================
  // one-slot input register
  // ==================================================
  assign in_ready = !dec_valid || dec_ready;  // empty or draining

  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else if (in_ready) begin
      dec_valid <= in_valid;
    end
  end

  // payload only moves on a transfer
  always_ff @(posedge forever_cpuclk) begin
    if (in_valid && in_ready) begin
      dec_inst <= inst;
      dec_br   <= br;
    end
  end

  // a stalled word must not change under the decoder
  a_hold_stable : assert property (
    @(posedge forever_cpuclk) disable iff (rst)
    (dec_valid && !dec_ready) |=> $stable(dec_inst)
  ) else $error("dec_inst changed while stalled");

endmodule

`default_nettype wire

/* logic/pdec_form_match.sv */
`timescale 1ns/1ps
`default_nettype none

module pdec_form_match import pdec_pkg::*; (
  input  wire inst_t dec_inst,
  output logic       is_jal32,
  output logic       is_jalr32,
  output logic       is_cj,
  output logic       is_cjr,
  output logic       is_cjalr,
  output logic       is_auipc,
  output logic       jalr_tgt_vld,  // register-indirect target
  output logic       jal_dst_vld    // writes a link value to rd
);

  opcode_t    opcode;
  reg_idx_t   rd;
  logic [2:0] funct3;
  logic       c_cr_op;
  logic       rd_nz;

  assign opcode = dec_inst[6:0];
  assign rd     = dec_inst[11:7];  // also rs1 of the rvc cr form
  assign funct3 = dec_inst[14:12];
  assign rd_nz  = (rd != REG_ZERO);

  // quadrant 2 with rs2 field zero
  assign c_cr_op = (dec_inst[6:0] == 7'b0000010);

  // ==================================================
  // 32-bit forms
  // ==================================================
  assign is_jal32  = (opcode == OPC_JAL);
  assign is_jalr32 = (opcode == OPC_JALR) && (funct3 == 3'b000);
  assign is_auipc  = (opcode == OPC_AUIPC);

  // ==================================================
  // compressed forms
  // ==================================================
  assign is_cjr   = (dec_inst[15:12] == 4'b1000) && c_cr_op && rd_nz;
  assign is_cjalr = (dec_inst[15:12] == 4'b1001) && c_cr_op && rd_nz;
  assign is_cj    = (dec_inst[15:13] == 3'b101) && (dec_inst[1:0] == 2'b01);

  assign jalr_tgt_vld = is_jalr32 || is_cjr || is_cjalr;

  // c.jalr always writes x1
  assign jal_dst_vld = ((is_jal32 || is_jalr32) && rd_nz) || is_cjalr;

  // slot is not loaded before the first transfer
  always_comb begin
    a_one_form32 : assert final (
      $isunknown(dec_inst) || $onehot0({is_jal32, is_jalr32, is_auipc})
    ) else $error("more than one 32-bit form matched");
  end

endmodule

`default_nettype wire

/* logic/pdec_flow_class.sv */
`timescale 1ns/1ps
`default_nettype none

module pdec_flow_class import pdec_pkg::*; (
  input  wire inst_t dec_inst,
  input  wire        dec_br,
  input  wire        is_jal32,
  input  wire        is_jalr32,
  input  wire        is_cj,
  input  wire        is_cjr,
  input  wire        is_cjalr,
  input  wire        is_auipc,
  input  wire        jalr_tgt_vld,
  input  wire        jal_dst_vld,
  output logic       auipc,
  output logic       jal,
  output logic       jalr,
  output logic       con_br,
  output logic       chgflw,
  output logic       branch,
  output logic       pc_oper,
  output logic       dst_vld
);

  logic abs_br;

  // ==================================================
  // branch hint split
  // ==================================================

  // the hint only says "some pc-relative branch", the word tells which
  assign abs_br = dec_br &&
                  ((dec_inst[2:1] == 2'b11) ||                // jal
                   ({dec_inst[14], dec_inst[1]} == 2'b00));   // c.j

  assign con_br = dec_br &&
                  ((dec_inst[2:1] == 2'b01) ||                // 32-bit bxx
                   ({dec_inst[14], dec_inst[1]} == 2'b10));   // c.beqz/c.bnez

  // ==================================================
  // class flags
  // ==================================================
  assign chgflw  = jalr_tgt_vld || abs_br;  // everything but cond branches
  assign branch  = jalr_tgt_vld || dec_br;  // includes cond branches
  assign pc_oper = dec_br || jalr_tgt_vld || is_auipc;
  assign auipc   = is_auipc;
  assign jal     = is_jal32 || is_cj;
  assign jalr    = jalr_tgt_vld;
  assign dst_vld = jal_dst_vld;

  // direct and indirect jump forms must never overlap
  always_comb begin
    a_jal_jalr_excl : assert final (
      $isunknown(dec_inst) ||
      !((is_jal32 || is_cj) && (is_jalr32 || is_cjr || is_cjalr))
    ) else $error("jal and jalr forms matched together");
  end

endmodule

`default_nettype wire

/* logic/pdec_ras_hint.sv */
`timescale 1ns/1ps
`default_nettype none

module pdec_ras_hint import pdec_pkg::*; (
  input  wire inst_t dec_inst,
  input  wire        is_jal32,
  input  wire        is_jalr32,
  input  wire        is_cjr,
  input  wire        is_cjalr,
  output logic       pcall,    // push
  output logic       preturn,  // pop
  output logic       ind_br    // indirect, no ras action
);

  reg_idx_t rd;
  reg_idx_t rs1;
  logic     rd_link;
  logic     rs1_link;
  logic     jalr_ret;

  function automatic logic is_link(input reg_idx_t idx);
    return (idx == REG_RA) || (idx == REG_T0);
  endfunction

  assign rd  = dec_inst[11:7];   // rvc cr form keeps rs1 here
  assign rs1 = dec_inst[19:15];

  assign rd_link  = is_link(rd);
  assign rs1_link = is_link(rs1);

  // ==================================================
  // ras action table
  // ==================================================
  //   rd     rs1    rs1==rd   action
  //   !link  !link  -         none
  //   !link  link   -         pop
  //   link   !link  -         push
  //   link   link   0         push and pop
  //   link   link   1         push only

  // plain jalr return, no offset
  assign jalr_ret = is_jalr32 && rs1_link && (rs1 != rd) &&
                    (dec_inst[31:20] == 12'h000);

  assign pcall = ((is_jal32 || is_jalr32) && rd_link) ||
                 is_cjalr;                            // c.jalr links x1

  assign preturn = jalr_ret ||
                   (is_cjr && rd_link) ||
                   (is_cjalr && (rd == REG_T0));      // x1 is its own rd

  assign ind_br = (is_jalr32 && !jalr_ret) ||
                  (is_cjr && !rd_link) ||
                  (is_cjalr && (rd != REG_T0));

endmodule

`default_nettype wire

/* logic/pdec_offset.sv */
`timescale 1ns/1ps
`default_nettype none

module pdec_offset import pdec_pkg::*; #(
  parameter int OFFSET_W = 21
) (
  input  wire inst_t         dec_inst,
  output logic [OFFSET_W-1:0] offset
);

  opcode_t            opcode;
  logic               sel_jal;
  logic               sel_jalr;
  logic               sel_b;
  logic               sel_cj;
  logic               sel_cb;
  logic signed [20:0] imm_jal;
  logic signed [11:0] imm_jalr;
  logic signed [12:0] imm_b;
  logic signed [11:0] imm_cj;
  logic signed [8:0]  imm_cb;

  assign opcode = dec_inst[6:0];

  // ==================================================
  // format selects
  // ==================================================
  assign sel_jal  = (opcode == OPC_JAL);
  assign sel_jalr = (opcode == OPC_JALR);    // any funct3
  assign sel_b    = (opcode == OPC_BRANCH);
  assign sel_cj   = ({dec_inst[15:13], dec_inst[1:0]} == 5'b101_01);
  assign sel_cb   = ({dec_inst[15:14], dec_inst[1:0]} == 4'b11_01);

  // ==================================================
  // immediates at native width
  // ==================================================
  assign imm_jal = {dec_inst[31], dec_inst[19:12], dec_inst[20],
                    dec_inst[30:21], 1'b0};

  assign imm_jalr = dec_inst[31:20];

  assign imm_b = {dec_inst[31], dec_inst[7], dec_inst[30:25],
                  dec_inst[11:8], 1'b0};

  // c.j: imm[11|4|9:8|10|6|7|3:1|5]
  assign imm_cj = {dec_inst[12], dec_inst[8], dec_inst[10:9], dec_inst[6],
                   dec_inst[7], dec_inst[2], dec_inst[11], dec_inst[5:3], 1'b0};

  // c.beqz/c.bnez: imm[8|4:3] in 12:10, imm[7:6|2:1|5] in 6:2
  assign imm_cb = {dec_inst[12], dec_inst[6:5], dec_inst[2],
                   dec_inst[11:10], dec_inst[4:3], 1'b0};

  // ==================================================
  // and-or select, zero when nothing matches
  // ==================================================
  assign offset = ({OFFSET_W{sel_jal}}  & OFFSET_W'(imm_jal))
                | ({OFFSET_W{sel_jalr}} & OFFSET_W'(imm_jalr))
                | ({OFFSET_W{sel_b}}    & OFFSET_W'(imm_b))
                | ({OFFSET_W{sel_cj}}   & OFFSET_W'(imm_cj))
                | ({OFFSET_W{sel_cb}}   & OFFSET_W'(imm_cb));  // casts sign-extend

  always_comb begin
    a_one_sel : assert final (
      $isunknown(dec_inst) ||
      $onehot0({sel_jal, sel_jalr, sel_b, sel_cj, sel_cb})
    ) else $error("overlapping offset formats");
  end

endmodule

`default_nettype wire

/* logic/pdec_out_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pdec_out_stage #(
  parameter int OFFSET_W = 21
) (
  input  wire                 forever_cpuclk,
  input  wire                 rst,
  // decode side
  input  wire                 dec_valid,
  output logic                dec_ready,
  input  wire                 auipc,
  input  wire                 branch,
  input  wire                 chgflw,
  input  wire                 con_br,
  input  wire                 dst_vld,
  input  wire                 ind_br,
  input  wire                 jal,
  input  wire                 jalr,
  input  wire                 pc_oper,
  input  wire                 pcall,
  input  wire                 preturn,
  input  wire [OFFSET_W-1:0]  offset,
  // consumer side
  output logic                out_valid,
  input  wire                 out_ready,
  output logic                o_auipc,
  output logic                o_branch,
  output logic                o_chgflw,
  output logic                o_con_br,
  output logic                o_dst_vld,
  output logic                o_ind_br,
  output logic                o_jal,
  output logic                o_jalr,
  output logic                o_pc_oper,
  output logic                o_pcall,
  output logic                o_preturn,
  output logic [OFFSET_W-1:0] o_offset
);

  // ==================================================
  // one-slot result register
  // ==================================================
  assign dec_ready = !out_valid || out_ready;

  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (dec_ready) begin
      out_valid <= dec_valid;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (dec_valid && dec_ready) begin
      o_auipc   <= auipc;
      o_branch  <= branch;
      o_chgflw  <= chgflw;
      o_con_br  <= con_br;
      o_dst_vld <= dst_vld;
      o_ind_br  <= ind_br;
      o_jal     <= jal;
      o_jalr    <= jalr;
      o_pc_oper <= pc_oper;
      o_pcall   <= pcall;
      o_preturn <= preturn;
      o_offset  <= offset;
    end
  end

  // result may not vanish before the sink takes it
  a_valid_held : assert property (
    @(posedge forever_cpuclk) disable iff (rst)
    (out_valid && !out_ready) |=> out_valid
  ) else $error("out_valid dropped without a transfer");

endmodule

`default_nettype wire

/* logic/pdec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pdec_top import pdec_pkg::*; #(
  parameter int OFFSET_W = 21
) (
  input  wire                 forever_cpuclk,
  input  wire                 rst,
  input  wire                 in_valid,
  output logic                in_ready,
  input  wire inst_t          inst,
  input  wire                 br,
  output logic                out_valid,
  input  wire                 out_ready,
  output logic                auipc,
  output logic                branch,
  output logic                chgflw,
  output logic                con_br,
  output logic                dst_vld,
  output logic                ind_br,
  output logic                jal,
  output logic                jalr,
  output logic                pc_oper,
  output logic                pcall,
  output logic                preturn,
  output logic [OFFSET_W-1:0] offset
);

  // ==================================================
  // stage 1 to decode
  // ==================================================
  logic  dec_valid;
  logic  dec_ready;
  inst_t dec_inst;
  logic  dec_br;

  // form strobes
  logic is_jal32;
  logic is_jalr32;
  logic is_cj;
  logic is_cjr;
  logic is_cjalr;
  logic is_auipc;
  logic jalr_tgt_vld;
  logic jal_dst_vld;

  // unregistered results
  logic                dec_auipc;
  logic                dec_branch;
  logic                dec_chgflw;
  logic                dec_con_br;
  logic                dec_dst_vld;
  logic                dec_ind_br;
  logic                dec_jal;
  logic                dec_jalr;
  logic                dec_pc_oper;
  logic                dec_pcall;
  logic                dec_preturn;
  logic [OFFSET_W-1:0] dec_offset;

  pdec_in_stage u_in_stage (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .inst           (inst),
    .br             (br),
    .dec_valid      (dec_valid),
    .dec_ready      (dec_ready),
    .dec_inst       (dec_inst),
    .dec_br         (dec_br)
  );

  // ==================================================
  // decode
  // ==================================================
  pdec_form_match u_form_match (
    .dec_inst     (dec_inst),
    .is_jal32     (is_jal32),
    .is_jalr32    (is_jalr32),
    .is_cj        (is_cj),
    .is_cjr       (is_cjr),
    .is_cjalr     (is_cjalr),
    .is_auipc     (is_auipc),
    .jalr_tgt_vld (jalr_tgt_vld),
    .jal_dst_vld  (jal_dst_vld)
  );

  pdec_flow_class u_flow_class (
    .dec_inst     (dec_inst),
    .dec_br       (dec_br),
    .is_jal32     (is_jal32),
    .is_jalr32    (is_jalr32),
    .is_cj        (is_cj),
    .is_cjr       (is_cjr),
    .is_cjalr     (is_cjalr),
    .is_auipc     (is_auipc),
    .jalr_tgt_vld (jalr_tgt_vld),
    .jal_dst_vld  (jal_dst_vld),
    .auipc        (dec_auipc),
    .jal          (dec_jal),
    .jalr         (dec_jalr),
    .con_br       (dec_con_br),
    .chgflw       (dec_chgflw),
    .branch       (dec_branch),
    .pc_oper      (dec_pc_oper),
    .dst_vld      (dec_dst_vld)
  );

  pdec_ras_hint u_ras_hint (
    .dec_inst  (dec_inst),
    .is_jal32  (is_jal32),
    .is_jalr32 (is_jalr32),
    .is_cjr    (is_cjr),
    .is_cjalr  (is_cjalr),
    .pcall     (dec_pcall),
    .preturn   (dec_preturn),
    .ind_br    (dec_ind_br)
  );

  pdec_offset #(
    .OFFSET_W (OFFSET_W)
  ) u_offset (
    .dec_inst (dec_inst),
    .offset   (dec_offset)
  );

  // ==================================================
  // stage 2
  // ==================================================
  pdec_out_stage #(
    .OFFSET_W (OFFSET_W)
  ) u_out_stage (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .dec_valid      (dec_valid),
    .dec_ready      (dec_ready),
    .auipc          (dec_auipc),
    .branch         (dec_branch),
    .chgflw         (dec_chgflw),
    .con_br         (dec_con_br),
    .dst_vld        (dec_dst_vld),
    .ind_br         (dec_ind_br),
    .jal            (dec_jal),
    .jalr           (dec_jalr),
    .pc_oper        (dec_pc_oper),
    .pcall          (dec_pcall),
    .preturn        (dec_preturn),
    .offset         (dec_offset),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .o_auipc        (auipc),
    .o_branch       (branch),
    .o_chgflw       (chgflw),
    .o_con_br       (con_br),
    .o_dst_vld      (dst_vld),
    .o_ind_br       (ind_br),
    .o_jal          (jal),
    .o_jalr         (jalr),
    .o_pc_oper      (pc_oper),
    .o_pcall        (pcall),
    .o_preturn      (preturn),
    .o_offset       (offset)
  );

endmodule

`default_nettype wire

/* verif/pdec_model.svh */
`ifndef PDEC_MODEL_SVH
`define PDEC_MODEL_SVH

// ==================================================
// random source
// ==================================================

// taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

// ==================================================
// reference decode
// ==================================================

// fetch hint for jal, c.j, bxx and c.beqz/c.bnez
function automatic logic branch_hint(input logic [31:0] w);
  logic q1;
  q1 = (w[1:0] == 2'b01);
  return (w[6:0] == 7'b1101111) || (w[6:0] == 7'b1100011) ||
         (q1 && (w[15:13] == 3'b101)) || (q1 && (w[15:14] == 2'b11));
endfunction

function automatic logic is_link_reg(input logic [4:0] r);
  return (r == 5'd1) || (r == 5'd5);
endfunction

// {auipc, branch, chgflw, con_br, dst_vld, jal, jalr, pc_oper, pcall, preturn, ind_br}
function automatic logic [10:0] model_flags(input logic [31:0] w, input logic b);
  logic [4:0] rd;
  logic [4:0] rs1;
  logic       j32;
  logic       jr32;
  logic       au;
  logic       cj;
  logic       cjr;
  logic       cjalr;
  logic       cr_ok;
  logic       tgt;
  logic       ret32;
  logic       abs_br;
  logic       cond;
  rd     = w[11:7];
  rs1    = w[19:15];
  j32    = (w[6:0] == 7'b1101111);
  jr32   = (w[6:0] == 7'b1100111) && (w[14:12] == 3'b000);
  au     = (w[6:0] == 7'b0010111);
  cr_ok  = (w[6:0] == 7'b0000010) && (rd != 5'd0);
  cjr    = (w[15:12] == 4'b1000) && cr_ok;
  cjalr  = (w[15:12] == 4'b1001) && cr_ok;
  cj     = (w[15:13] == 3'b101) && (w[1:0] == 2'b01);
  tgt    = jr32 || cjr || cjalr;
  abs_br = b && ((w[2:1] == 2'b11) || (!w[14] && !w[1]));
  cond   = b && ((w[2:1] == 2'b01) || (w[14] && !w[1]));
  ret32  = jr32 && is_link_reg(rs1) && (rs1 != rd) && (w[31:20] == 12'd0);
  return {au,
          tgt || b,                               // branch
          tgt || abs_br,                          // chgflw
          cond,
          ((j32 || jr32) && (rd != 5'd0)) || cjalr,  // dst_vld
          j32 || cj,
          tgt,
          b || tgt || au,                         // pc_oper
          ((j32 || jr32) && is_link_reg(rd)) || cjalr,
          ret32 || (cjr && is_link_reg(rd)) || (cjalr && (rd == 5'd5)),
          (jr32 && !ret32) || (cjr && !is_link_reg(rd)) || (cjalr && (rd != 5'd5))};
endfunction

// sign-extended immediate, zero for words without one
function automatic logic [20:0] model_offset(input logic [31:0] w);
  logic [20:0] imm;
  int          sb;
  int          i;
  imm = '0;
  sb  = -1;
  if (w[6:0] == 7'b1101111) begin  // jal
    imm[20]    = w[31];
    imm[19:12] = w[19:12];
    imm[11]    = w[20];
    imm[10:1]  = w[30:21];
    sb         = 20;
  end else if (w[6:0] == 7'b1100111) begin  // jalr, any funct3
    imm[11:0] = w[31:20];
    sb        = 11;
  end else if (w[6:0] == 7'b1100011) begin  // bxx
    imm[12]   = w[31];
    imm[11]   = w[7];
    imm[10:5] = w[30:25];
    imm[4:1]  = w[11:8];
    sb        = 12;
  end else if ((w[1:0] == 2'b01) && (w[15:13] == 3'b101)) begin  // c.j
    imm[11]  = w[12];
    imm[10]  = w[8];
    imm[9:8] = w[10:9];
    imm[7]   = w[6];
    imm[6]   = w[7];
    imm[5]   = w[2];
    imm[4]   = w[11];
    imm[3:1] = w[5:3];
    sb       = 11;
  end else if ((w[1:0] == 2'b01) && (w[15:14] == 2'b11)) begin  // c.beqz/c.bnez
    imm[8]   = w[12];
    imm[7:6] = w[6:5];
    imm[5]   = w[2];
    imm[4:3] = w[11:10];
    imm[2:1] = w[4:3];
    sb       = 8;
  end
  for (i = 0; i < 21; i++) begin
    if ((sb >= 0) && (i > sb)) imm[i] = imm[sb];
  end
  return imm;
endfunction

`endif

/* verif/pdec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pdec_tb;

  localparam int          OFFSET_W       = 21;
  localparam int          NUM_WORDS      = 400;
  localparam int          LAT_WORDS      = 16;  // leading words see no stalls
  localparam int          TIMEOUT_CYCLES = NUM_WORDS * 8 + 200;
  localparam logic [15:0] SEED           = 16'd59584;

  logic                forever_cpuclk;
  logic                rst;
  logic                in_valid;
  logic                in_ready;
  logic [31:0]         inst;
  logic                br;
  logic                out_valid;
  logic                out_ready;
  logic                auipc;
  logic                branch;
  logic                chgflw;
  logic                con_br;
  logic                dst_vld;
  logic                ind_br;
  logic                jal;
  logic                jalr;
  logic                pc_oper;
  logic                pcall;
  logic                preturn;
  logic [OFFSET_W-1:0] offset;

  logic [15:0] lfsr_state;
  logic        in_xfer;
  int          cycle_cnt;
  int          sent;
  int          popped;
  int          checks;
  int          class_errs;
  int          ras_errs;
  int          offset_errs;
  int          flow_errs;

  // scoreboard, one entry per accepted word
  logic [10:0]         exp_flags_q[$];
  logic [OFFSET_W-1:0] exp_off_q[$];
  logic [31:0]         exp_inst_q[$];
  int                  exp_idx_q[$];
  int                  exp_cyc_q[$];

  `include "pdec_model.svh"

  pdec_top #(
    .OFFSET_W (OFFSET_W)
  ) u_pdec_top (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .inst           (inst),
    .br             (br),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .auipc          (auipc),
    .branch         (branch),
    .chgflw         (chgflw),
    .con_br         (con_br),
    .dst_vld        (dst_vld),
    .ind_br         (ind_br),
    .jal            (jal),
    .jalr           (jalr),
    .pc_oper        (pc_oper),
    .pcall          (pcall),
    .preturn        (preturn),
    .offset         (offset)
  );

  always #2 forever_cpuclk = ~forever_cpuclk;

  // ==================================================
  // stimulus helpers
  // ==================================================
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // x0, ra, t0 or any register
  function automatic logic [4:0] pick_reg();
    logic [31:0] rnd;
    rnd = rand_bits(2);
    case (rnd[1:0])
      2'd0:    return 5'd0;
      2'd1:    return 5'd1;
      2'd2:    return 5'd5;
      default: begin
        rnd = rand_bits(5);
        return rnd[4:0];
      end
    endcase
  endfunction

  function automatic logic [31:0] make_word();
    logic [31:0] rnd;
    logic [31:0] w;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [2:0]  f3;
    logic [11:0] imm12;
    int          tmpl;
    rnd  = rand_bits(4);
    tmpl = rnd % 9;
    rd   = pick_reg();
    rs1  = pick_reg();
    case (tmpl)
      0: begin
        rnd = rand_bits(20);
        w   = {rnd[19:0], rd, 7'b1101111};  // jal
      end
      1: begin
        rnd   = rand_bits(5);
        f3    = (rnd[4:3] == 2'b00) ? rnd[2:0] : 3'b000;  // odd funct3 now and then
        rnd   = rand_bits(13);
        imm12 = rnd[12] ? 12'h000 : rnd[11:0];  // half are plain returns
        w     = {imm12, rs1, f3, rd, 7'b1100111};
      end
      2: begin
        rnd = rand_bits(27);
        w   = {rnd[26:11], 3'b101, rnd[10:0], 2'b01};  // c.j
      end
      3: begin
        rnd = rand_bits(16);
        w   = {rnd[15:0], 4'b1000, rd, 7'b0000010};  // c.jr
      end
      4: begin
        rnd = rand_bits(16);
        w   = {rnd[15:0], 4'b1001, rd, 7'b0000010};  // c.jalr
      end
      5: begin
        rnd = rand_bits(20);
        w   = {rnd[19:13], rnd[12:8], rs1, rnd[7:5], rnd[4:0], 7'b1100011};  // bxx
      end
      6: begin
        rnd = rand_bits(28);
        w   = {rnd[27:12], 2'b11, rnd[11:0], 2'b01};  // c.beqz/c.bnez
      end
      7: begin
        rnd = rand_bits(20);
        w   = {rnd[19:0], rd, 7'b0010111};  // auipc
      end
      default: w = rand_bits(32);
    endcase
    return w;
  endfunction

  // ==================================================
  // per-cycle drive and sample
  // ==================================================
  task automatic drive_inputs();
    logic [31:0] rnd;
    logic [31:0] w;
    if (!(in_valid && !in_xfer)) begin  // nothing held from last cycle
      rnd = rand_bits(2);
      if ((sent < NUM_WORDS) && (rnd[1:0] != 2'b00)) begin
        w        = make_word();
        inst     = w;
        br       = branch_hint(w);
        in_valid = 1'b1;
      end else begin
        in_valid = 1'b0;
      end
    end
    rnd       = rand_bits(2);
    out_ready = (popped < LAT_WORDS) || (rnd[1:0] != 2'b00);
  endtask

  task automatic sample_transfers();
    logic [10:0]         got;
    logic [10:0]         exp;
    logic [OFFSET_W-1:0] exp_off;
    logic [31:0]         w;
    int                  idx;
    int                  cyc;
    if (out_valid && out_ready) begin
      if (exp_flags_q.size() == 0) begin
        $display("output word at %0t ns with no accepted input pending", $time);
        flow_errs++;
      end else begin
        exp     = exp_flags_q.pop_front();
        exp_off = exp_off_q.pop_front();
        w       = exp_inst_q.pop_front();
        idx     = exp_idx_q.pop_front();
        cyc     = exp_cyc_q.pop_front();
        got     = {auipc, branch, chgflw, con_br, dst_vld, jal, jalr, pc_oper,
                   pcall, preturn, ind_br};
        checks++;
        popped++;
        assert (got[10:3] === exp[10:3]) else begin
          $display("[FAIL] %0t ns: word %0d (%08h) class flags %b, expected %b",
                   $time, idx, w, got[10:3], exp[10:3]);
          class_errs++;
        end
        assert (got[2:0] === exp[2:0]) else begin
          $display("[FAIL] %0t ns: word %0d (%08h) pcall/preturn/ind_br %b, expected %b",
                   $time, idx, w, got[2:0], exp[2:0]);
          ras_errs++;
        end
        assert (offset === exp_off) else begin
          $display("[FAIL] %0t ns: word %0d (%08h) offset %h, expected %h",
                   $time, idx, w, offset, exp_off);
          offset_errs++;
        end
        if (idx < LAT_WORDS) begin
          assert (cycle_cnt - cyc == 2) else begin
            $display("[FAIL] %0t ns: word %0d latency %0d cycles, expected 2",
                     $time, idx, cycle_cnt - cyc);
            flow_errs++;
          end
        end
      end
    end
    in_xfer = in_valid && in_ready;
    if (in_xfer) begin
      exp_flags_q.push_back(model_flags(inst, br));
      exp_off_q.push_back(model_offset(inst));
      exp_inst_q.push_back(inst);
      exp_idx_q.push_back(sent);
      exp_cyc_q.push_back(cycle_cnt);
      sent++;
    end
  endtask

  task automatic print_counts();
    $display("words checked %0d, errors: class %0d, ras %0d, offset %0d, flow %0d",
             checks, class_errs, ras_errs, offset_errs, flow_errs);
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    forever_cpuclk = 1'b0;
    rst            = 1'b1;
    in_valid       = 1'b0;
    inst           = '0;
    br             = 1'b0;
    out_ready      = 1'b0;
    lfsr_state     = SEED;
    in_xfer        = 1'b0;
    cycle_cnt      = 0;
    sent           = 0;
    popped         = 0;
    checks         = 0;
    class_errs     = 0;
    ras_errs       = 0;
    offset_errs    = 0;
    flow_errs      = 0;
    repeat (16) @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    rst = 1'b0;
    #1;
    assert ((in_ready === 1'b1) && (out_valid === 1'b0)) else begin
      $display("[FAIL] %0t ns: after reset in_ready %b out_valid %b", $time,
               in_ready, out_valid);
      flow_errs++;
    end
    while (popped < NUM_WORDS) begin
      @(negedge forever_cpuclk);
      drive_inputs();
      #1;  // settle before the next rising edge
      sample_transfers();
    end
    // drained, nothing may come out twice
    repeat (4) begin
      @(negedge forever_cpuclk);
      in_valid  = 1'b0;
      out_ready = 1'b1;
      #1;
      assert (out_valid === 1'b0) else begin
        $display("[FAIL] %0t ns: out_valid high after all words were taken", $time);
        flow_errs++;
      end
    end
    print_counts();
    if (class_errs + ras_errs + offset_errs + flow_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // cycle count and run limit
  always @(posedge forever_cpuclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d words came out",
               cycle_cnt, popped, NUM_WORDS);
      print_counts();
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+verif
logic/pdec_pkg.sv
logic/pdec_in_stage.sv
logic/pdec_form_match.sv
logic/pdec_flow_class.sv
logic/pdec_ras_hint.sv
logic/pdec_offset.sv
logic/pdec_out_stage.sv
logic/pdec_top.sv
verif/pdec_tb.sv
